// ==== logic/sdmac_cfg.svh ====
`ifndef SDMAC_CFG_SVH
`define SDMAC_CFG_SVH

// Register word indices, addr[6:2]
`define SDMAC_DAWR_IDX      5'd0   // Data acknowledge width
`define SDMAC_WTC_IDX       5'd1   // Word transfer count
`define SDMAC_CNTR_IDX      5'd2   // Control
`define SDMAC_ST_DMA_IDX    5'd3   // Start DMA strobe
`define SDMAC_FLUSH_IDX     5'd4   // Flush strobe
`define SDMAC_CLR_INT_IDX   5'd7   // Clear interrupt strobe
`define SDMAC_ISTR_IDX      5'd8   // Interrupt status, read only
`define SDMAC_SP_DMA_IDX    5'd9   // Stop DMA strobe

// Peripheral ranges, first word index of each
`define SDMAC_CSS_BASE      5'd16  // 16..23, SCSI chip
`define SDMAC_CSX0_BASE     5'd24  // 24..27
`define SDMAC_CSX1_BASE     5'd28  // 28..31

// Port strobe timing in sclk cycles
`define SDMAC_IO_SETUP      1      // Select ahead of strobe
`define SDMAC_IO_STROBE     3      // Minimum ior/iow width
`define SDMAC_IORDY_LIMIT   15     // Give up on iordy after this

`endif

// ==== logic/sdmac_pkg.sv ====
`default_nettype none

package sdmac_pkg;

    // Host side
    typedef logic [31:0] bus_data_t;   // 68030 data word
    typedef logic [4:0]  reg_idx_t;    // Word index, addr[6:2]

    // Peripheral side
    typedef logic [15:0] port_data_t;  // 16-bit device port

    // Register contents
    typedef logic [23:0] wtc_t;        // Word transfer count
    typedef logic [1:0]  dawr_t;       // Acknowledge width
    typedef logic [5:0]  cntr_t;       // Control bits, bit 2 is int enable
    typedef logic [31:0] istr_t;       // Interrupt status

    // Where a decoded host access goes
    typedef enum logic [1:0] {
        tgt_none,                      // Unmapped or a12 high
        tgt_reg,                       // Internal register
        tgt_port                       // One of the peripheral selects
    } target_e;

    // Peripheral port sequencer
    typedef enum logic [2:0] {
        ps_idle,                       // Waiting for port_req
        ps_setup,                      // Select up, strobe not yet
        ps_strobe,                     // ior/iow minimum width
        ps_wait,                       // Strobe stretched on iordy low
        ps_hold                        // Strobe off, select still up
    } port_state_e;

endpackage : sdmac_pkg

`default_nettype wire

// ==== logic/sdmac_addr_decoder.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "sdmac_cfg.svh"

module sdmac_addr_decoder import sdmac_pkg::*; (
    input  logic       sclk,
    input  logic       reset,
    input  logic       cs,        // Host access level
    input  logic       a12,       // High means another card owns it
    input  reg_idx_t   addr,      // addr[6:2]
    input  logic       done,      // Access acknowledged
    output logic       reg_req,   // One cycle pulse
    output logic       port_req,  // One cycle pulse
    output reg_idx_t   reg_idx,
    output logic [2:0] port_sel   // [0] css, [1] csx0, [2] csx1
);

    target_e    tgt;              // Combinational classification
    logic [2:0] sel;
    logic       busy;             // One access per cs assertion
    logic       start;

    assign start = cs && !busy;

    always_comb begin
        tgt = tgt_none;
        sel = 3'b000;
        if (!a12) begin
            case (addr)
                `SDMAC_DAWR_IDX, `SDMAC_WTC_IDX, `SDMAC_CNTR_IDX,
                `SDMAC_ST_DMA_IDX, `SDMAC_FLUSH_IDX, `SDMAC_CLR_INT_IDX,
                `SDMAC_ISTR_IDX, `SDMAC_SP_DMA_IDX: tgt = tgt_reg;
                default: tgt = tgt_none;   // Holes 5, 6 and 10..15
            endcase
            if (addr >= `SDMAC_CSX1_BASE) begin
                tgt = tgt_port;
                sel = 3'b100;
            end else if (addr >= `SDMAC_CSX0_BASE) begin
                tgt = tgt_port;
                sel = 3'b010;
            end else if (addr >= `SDMAC_CSS_BASE) begin
                tgt = tgt_port;
                sel = 3'b001;
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (reset) begin
            busy     <= 1'b0;
            reg_req  <= 1'b0;
            port_req <= 1'b0;
            reg_idx  <= '0;
            port_sel <= 3'b000;
        end else begin
            reg_req  <= start && (tgt == tgt_reg);
            port_req <= start && (tgt == tgt_port);
            if (start) begin
                busy    <= 1'b1;       // Set even for ignored accesses
                reg_idx <= addr;
            end else if (!cs) begin
                busy <= 1'b0;          // Host released the bus
            end
            if (start && (tgt == tgt_port))
                port_sel <= sel;
            else if (done)
                port_sel <= 3'b000;    // Valid until the ack
        end
    end

endmodule : sdmac_addr_decoder

`default_nettype wire

// ==== logic/sdmac_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "sdmac_cfg.svh"

module sdmac_regs import sdmac_pkg::*; (
    input  logic      sclk,
    input  logic      reset,
    input  logic      reg_req,     // From decoder, one cycle
    input  reg_idx_t  reg_idx,
    input  logic      read,
    input  bus_data_t data_in,
    input  logic      inta,        // SCSI chip interrupt
    input  logic      intb,        // Spare interrupt
    output logic      reg_done,    // One cycle after reg_req
    output bus_data_t reg_rdata,
    output logic      int_req,
    output logic      dma_en
);

    dawr_t     dawr;
    wtc_t      wtc;
    cntr_t     cntr;
    istr_t     istr;               // Live status view
    bus_data_t rdata_nxt;

    logic      wr_en;
    logic      hit_st_dma;
    logic      hit_sp_dma;
    logic      hit_flush;
    logic      hit_clr_int;

    logic      inta_q;             // Previous samples for edge detect
    logic      intb_q;
    logic      inta_rise;
    logic      intb_rise;
    logic      int_a_lat;          // ISTR bit 0
    logic      int_b_lat;          // ISTR bit 1
    logic      dma_active;         // ISTR bit 2
    logic      flushed;            // ISTR bit 3

    assign wr_en       = reg_req && !read;
    // Command strobes fire on any access, read or write
    assign hit_st_dma  = reg_req && (reg_idx == `SDMAC_ST_DMA_IDX);
    assign hit_sp_dma  = reg_req && (reg_idx == `SDMAC_SP_DMA_IDX);
    assign hit_flush   = reg_req && (reg_idx == `SDMAC_FLUSH_IDX);
    assign hit_clr_int = reg_req && (reg_idx == `SDMAC_CLR_INT_IDX);

    assign inta_rise = inta && !inta_q;
    assign intb_rise = intb && !intb_q;

    assign istr    = {28'd0, flushed, dma_active, int_b_lat, int_a_lat};
    assign int_req = cntr[2] && (int_a_lat || int_b_lat);   // Gated by int enable
    assign dma_en  = dma_active;

    always_comb begin
        case (reg_idx)
            `SDMAC_DAWR_IDX: rdata_nxt = {30'd0, dawr};
            `SDMAC_WTC_IDX:  rdata_nxt = {8'd0, wtc};
            `SDMAC_CNTR_IDX: rdata_nxt = {26'd0, cntr};
            `SDMAC_ISTR_IDX: rdata_nxt = istr;
            default:         rdata_nxt = '0;   // Strobes and holes read zero
        endcase
    end

    always_ff @(posedge sclk) begin
        if (reset) begin
            reg_done   <= 1'b0;
            dawr       <= '0;
            wtc        <= '0;
            cntr       <= '0;
            inta_q     <= 1'b0;
            intb_q     <= 1'b0;
            int_a_lat  <= 1'b0;
            int_b_lat  <= 1'b0;
            dma_active <= 1'b0;
            flushed    <= 1'b0;
        end else begin
            reg_done <= reg_req;
            inta_q   <= inta;
            intb_q   <= intb;
            if (wr_en && (reg_idx == `SDMAC_DAWR_IDX))
                dawr <= data_in[1:0];
            if (wr_en && (reg_idx == `SDMAC_WTC_IDX))
                wtc <= data_in[23:0];
            if (wr_en && (reg_idx == `SDMAC_CNTR_IDX))
                cntr <= data_in[5:0];
            // Clear first so a new edge in the same cycle survives
            if (hit_clr_int) begin
                int_a_lat <= 1'b0;
                int_b_lat <= 1'b0;
            end
            if (inta_rise)
                int_a_lat <= 1'b1;
            if (intb_rise)
                int_b_lat <= 1'b1;
            if (hit_st_dma) begin
                dma_active <= 1'b1;
                flushed    <= 1'b0;    // Fresh transfer
            end else if (hit_sp_dma) begin
                dma_active <= 1'b0;
            end
            if (hit_flush)
                flushed <= 1'b1;
        end
    end

    always_ff @(posedge sclk) begin
        if (reg_req)
            reg_rdata <= rdata_nxt;    // Held with reg_done
    end

endmodule : sdmac_regs

`default_nettype wire

// ==== logic/sdmac_periph_port.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "sdmac_cfg.svh"

module sdmac_periph_port import sdmac_pkg::*; (
    input  logic       sclk,
    input  logic       reset,
    input  logic       port_req,   // Start pulse from decoder
    input  logic [2:0] port_sel,   // One-hot css/csx0/csx1
    input  logic       read,
    input  bus_data_t  data_in,
    input  port_data_t pd_in,
    input  logic       iordy,      // Low iordy stretches the strobe
    output logic       port_done,  // One cycle after hold
    output bus_data_t  port_rdata,
    output logic       css,
    output logic       csx0,
    output logic       csx1,
    output logic       ior,
    output logic       iow,
    output port_data_t pd_out,
    output logic       pd_oe
);

    localparam int STEP_W = $clog2(`SDMAC_IO_SETUP + `SDMAC_IO_STROBE + 1);
    localparam int WAIT_W = $clog2(`SDMAC_IORDY_LIMIT + 1);

    port_state_e       state;
    logic [STEP_W-1:0] step_cnt;   // Setup and strobe phases
    logic [WAIT_W-1:0] wait_cnt;   // iordy low cycles
    logic [2:0]        sel_q;      // Latched select for the whole cycle
    logic              rd_q;
    port_data_t        wdata_q;
    port_data_t        rdata_q;
    logic              active;
    logic              strobing;

    assign active   = (state != ps_idle);
    assign strobing = (state == ps_strobe) || (state == ps_wait);

    assign css  = active && sel_q[0];
    assign csx0 = active && sel_q[1];
    assign csx1 = active && sel_q[2];
    assign ior  = strobing && rd_q;
    assign iow  = strobing && !rd_q;
    assign pd_oe  = active && !rd_q;       // Drive port setup through hold
    assign pd_out = wdata_q;
    assign port_rdata = {16'd0, rdata_q};

    always_ff @(posedge sclk) begin
        if (reset) begin
            state     <= ps_idle;
            step_cnt  <= '0;
            wait_cnt  <= '0;
            sel_q     <= 3'b000;
            rd_q      <= 1'b0;
            port_done <= 1'b0;
        end else begin
            port_done <= 1'b0;
            case (state)
                ps_idle: if (port_req) begin
                    sel_q    <= port_sel;
                    rd_q     <= read;
                    step_cnt <= STEP_W'(`SDMAC_IO_SETUP - 1);
                    state    <= ps_setup;
                end
                ps_setup: begin
                    if (step_cnt == '0) begin
                        step_cnt <= STEP_W'(`SDMAC_IO_STROBE - 1);
                        wait_cnt <= '0;
                        state    <= ps_strobe;
                    end else begin
                        step_cnt <= step_cnt - 1'b1;
                    end
                end
                ps_strobe: begin
                    if (step_cnt != '0)
                        step_cnt <= step_cnt - 1'b1;
                    else if (iordy)
                        state <= ps_hold;      // Minimum width met
                    else
                        state <= ps_wait;
                end
                ps_wait: begin
                    if (iordy || (wait_cnt == WAIT_W'(`SDMAC_IORDY_LIMIT)))
                        state <= ps_hold;      // Ready or timed out
                    else
                        wait_cnt <= wait_cnt + 1'b1;
                end
                ps_hold: begin
                    port_done <= 1'b1;
                    state     <= ps_idle;
                end
                default: state <= ps_idle;
            endcase
        end
    end

    // Write data latched at request and read data in the last strobe cycle
    always_ff @(posedge sclk) begin
        if ((state == ps_idle) && port_req)
            wdata_q <= data_in[15:0];
        if (rd_q
            && (((state == ps_strobe) && (step_cnt == '0) && iordy)
                || ((state == ps_wait) && (iordy
                    || (wait_cnt == WAIT_W'(`SDMAC_IORDY_LIMIT))))))
            rdata_q <= pd_in;
    end

endmodule : sdmac_periph_port

`default_nettype wire

// ==== logic/sdmac_bus_resp.sv ====
`default_nettype none
`timescale 1ns/10ps

module sdmac_bus_resp import sdmac_pkg::*; (
    input  logic      sclk,
    input  logic      reset,
    input  logic      read,        // Host direction, held with cs
    input  logic      reg_done,
    input  bus_data_t reg_rdata,
    input  logic      port_done,
    input  bus_data_t port_rdata,
    input  logic      dma_en,
    output logic      ack,         // One cycle per access
    output bus_data_t data_out,
    output logic      data_oe,     // Only with ack on reads
    output logic      led_rd,
    output logic      led_wr,
    output logic      led_dma
);

    localparam int LED_HOLD = 8;   // LED stretch in cycles

    logic       any_done;
    logic [3:0] led_cnt;           // Counts down from LED_HOLD
    logic       led_was_rd;        // Direction of last access

    assign any_done = reg_done || port_done;   // Never both at once

    assign led_rd = (led_cnt != '0) && led_was_rd;
    assign led_wr = (led_cnt != '0) && !led_was_rd;

    always_ff @(posedge sclk) begin
        if (reset) begin
            ack        <= 1'b0;
            data_oe    <= 1'b0;
            led_cnt    <= '0;
            led_was_rd <= 1'b0;
            led_dma    <= 1'b0;
        end else begin
            ack     <= any_done;
            data_oe <= any_done && read;
            led_dma <= dma_en;
            if (any_done) begin
                led_cnt    <= 4'(LED_HOLD);    // Restart stretch
                led_was_rd <= read;
            end else if (led_cnt != '0) begin
                led_cnt <= led_cnt - 1'b1;
            end
        end
    end

    // Read data, meaningful only while ack is high
    always_ff @(posedge sclk) begin
        if (reg_done)
            data_out <= reg_rdata;
        else if (port_done)
            data_out <= port_rdata;    // Upper half already zero
    end

endmodule : sdmac_bus_resp

`default_nettype wire

// ==== logic/sdmac_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module sdmac_top import sdmac_pkg::*; (
    input  logic       sclk,
    input  logic       reset,
    // Host bus
    input  logic       cs,
    input  logic       a12,
    input  reg_idx_t   addr,
    input  logic       read,
    input  bus_data_t  data_in,
    output logic       ack,
    output bus_data_t  data_out,
    output logic       data_oe,
    // Interrupts and DMA status
    input  logic       inta,
    input  logic       intb,
    output logic       int_req,
    output logic       dma_en,
    // Peripheral port
    input  logic       iordy,
    input  port_data_t pd_in,
    output logic       css,
    output logic       csx0,
    output logic       csx1,
    output logic       ior,
    output logic       iow,
    output port_data_t pd_out,
    output logic       pd_oe,
    // Activity LEDs
    output logic       led_rd,
    output logic       led_wr,
    output logic       led_dma
);

    logic       reg_req;
    logic       port_req;
    reg_idx_t   reg_idx;
    logic [2:0] port_sel;
    logic       reg_done;
    bus_data_t  reg_rdata;
    logic       port_done;
    bus_data_t  port_rdata;

    sdmac_addr_decoder i_decoder (
        .sclk, .reset, .cs, .a12, .addr,
        .done(ack),                        // Ack ends the access
        .reg_req, .port_req, .reg_idx, .port_sel
    );

    sdmac_regs i_regs (
        .sclk, .reset, .reg_req, .reg_idx, .read, .data_in,
        .inta, .intb, .reg_done, .reg_rdata, .int_req, .dma_en
    );

    sdmac_periph_port i_port (
        .sclk, .reset, .port_req, .port_sel, .read, .data_in, .pd_in, .iordy,
        .port_done, .port_rdata, .css, .csx0, .csx1, .ior, .iow, .pd_out, .pd_oe
    );

    sdmac_bus_resp i_resp (
        .sclk, .reset, .read, .reg_done, .reg_rdata, .port_done, .port_rdata,
        .dma_en, .ack, .data_out, .data_oe, .led_rd, .led_wr, .led_dma
    );

endmodule : sdmac_top

`default_nettype wire

// ==== verification/sdmac_sva.sv ====
`default_nettype none
`timescale 1ns/10ps

module sdmac_sva (
    input logic sclk,
    input logic reset,
    input logic ack,
    input logic data_oe,
    input logic css,
    input logic csx0,
    input logic csx1,
    input logic ior,
    input logic iow
);

    logic any_sel;                 // Some peripheral selected
    assign any_sel = css || csx0 || csx1;

    ack_one_cycle: assert property (@(posedge sclk) disable iff (reset) ack |=> !ack)
        else $error("ack stayed high for more than one cycle");

    sel_onehot: assert property (@(posedge sclk) disable iff (reset)
        $onehot0({css, csx0, csx1}))
        else $error("more than one peripheral select high");

    strobe_excl: assert property (@(posedge sclk) disable iff (reset) !(ior && iow))
        else $error("ior and iow high together");

    strobe_has_sel: assert property (@(posedge sclk) disable iff (reset)
        (ior || iow) |-> any_sel)
        else $error("strobe high without a select");

    oe_with_ack: assert property (@(posedge sclk) disable iff (reset) data_oe |-> ack)
        else $error("data_oe high outside an ack cycle");

endmodule : sdmac_sva

`default_nettype wire

// ==== verification/sdmac_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "sdmac_cfg.svh"

module sdmac_tb import sdmac_pkg::*; ();

    localparam logic [31:0] LFSR_SEED = 32'hbb0b7415;
    localparam logic [31:0] LFSR_POLY = 32'h80200003;   // x^32+x^22+x^2+x+1

    logic sclk = 1'b0;
    logic reset, cs, a12, read, inta, intb;
    reg_idx_t addr;
    bus_data_t data_in, data_out;
    logic iordy = 1'b1;            // Driven by the device model
    port_data_t pd_in = '0;
    port_data_t pd_out;
    logic ack, data_oe, int_req, dma_en, css, csx0, csx1, ior, iow, pd_oe;
    logic led_rd, led_wr, led_dma;

    logic [31:0] lfsr;
    int checks = 0;
    int errors = 0;

    // Device model state
    port_data_t dev_mem [3];       // Last written value per select
    logic [2:0] seen_sel;          // {csx1, csx0, css} at strobe start
    port_data_t seen_pd;
    logic seen_oe;                 // pd_oe at strobe start
    logic strobe_q;
    int dly_cnt;

    // Reference model
    dawr_t m_dawr;
    wtc_t m_wtc;
    cntr_t m_cntr;
    logic m_inta, m_intb, m_dma, m_flush;
    port_data_t m_mem [3];

    sdmac_top i_sdmac_top (.*);

    bind sdmac_top sdmac_sva i_sva (.sclk, .reset, .ack, .data_oe, .css, .csx0, .csx1,
                                    .ior, .iow);

    always #50 sclk = ~sclk;

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic int sel_index(input logic [2:0] v);
        if (v[2])
            return 2;
        if (v[1])
            return 1;
        return 0;
    endfunction

    function automatic bus_data_t model_istr();
        return {28'd0, m_flush, m_dma, m_intb, m_inta};
    endfunction

    // Device answers each strobe with a random iordy delay of 0..5 cycles
    always @(negedge sclk) begin : device_model
        int d;
        if (reset) begin
            iordy    <= 1'b1;
            strobe_q <= 1'b0;
            dly_cnt  <= 0;
            for (d = 0; d < 3; d++)
                dev_mem[d] <= '0;
        end else begin
            strobe_q <= ior || iow;
            if ((ior || iow) && !strobe_q) begin
                d = int'(rand_bits(3) % 6);
                dly_cnt  <= d;
                iordy    <= (d == 0);
                seen_sel <= {csx1, csx0, css};
                seen_oe  <= pd_oe;
                if (ior)
                    pd_in <= dev_mem[sel_index({csx1, csx0, css})] ^ 16'h5a5a;
                if (iow) begin
                    seen_pd <= pd_out;
                    dev_mem[sel_index({csx1, csx0, css})] <= pd_out;
                end
            end else if (dly_cnt != 0) begin
                dly_cnt <= dly_cnt - 1;
                iordy   <= (dly_cnt == 1);  // Ready on the last count
            end else begin
                iordy <= 1'b1;
            end
        end
    end

    task automatic compare(input string name, input bus_data_t exp, input bus_data_t got);
        checks++;
        if (exp !== got) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d %s: %0d errors", num, name, errors - err_before);
    endtask

    // Holds cs until ack or the cycle limit, then releases the bus
    task automatic host_access(input logic rd, input reg_idx_t a, input logic hi,
                               input bus_data_t wd, input int limit,
                               output bus_data_t rdv, output logic oe, output int cyc,
                               output logic got, output logic port_seen);
        int n;
        n = 0;
        got = 1'b0;
        oe = 1'b0;
        rdv = '0;
        port_seen = 1'b0;
        @(negedge sclk);
        cs      = 1'b1;
        a12     = hi;
        addr    = a;
        read    = rd;
        data_in = wd;
        while (!got && (n < limit)) begin
            @(negedge sclk);
            n++;
            port_seen = port_seen | css | csx0 | csx1 | ior | iow;
            if (ack) begin
                got = 1'b1;
                rdv = data_out;            // Valid only in the ack cycle
                oe  = data_oe;
            end
        end
        cyc = n;
        cs  = 1'b0;
        a12 = 1'b0;
        @(negedge sclk);                   // cs low for a full cycle
    endtask

    task automatic reg_access(input logic rd, input reg_idx_t idx, input bus_data_t wd,
                              output bus_data_t rdv);
        logic oe, got, seen;
        int cyc;
        host_access(rd, idx, 1'b0, wd, 20, rdv, oe, cyc, got, seen);
        if (!got) begin
            $display("error at %0t: no ack for register index %0d", $time, idx);
            errors++;
        end else begin
            compare("ack latency", 32'd3, 32'(cyc));   // decode, regs, resp
            compare("data_oe", 32'(rd), 32'(oe));
            compare("led_rd", 32'(rd), 32'(led_rd));
            compare("led_wr", 32'(!rd), 32'(led_wr));
        end
    endtask

    task automatic check_status();
        bus_data_t rdv;
        reg_access(1'b1, `SDMAC_ISTR_IDX, '0, rdv);
        compare("istr", model_istr(), rdv);
        compare("int_req", 32'(m_cntr[2] && (m_inta || m_intb)), 32'(int_req));
        compare("dma_en", 32'(m_dma), 32'(dma_en));
        compare("led_dma", 32'(m_dma), 32'(led_dma));
    endtask

    task automatic pulse_int(input logic which);
        @(negedge sclk);
        if (which)
            intb = 1'b1;
        else
            inta = 1'b1;
        @(negedge sclk);
        inta = 1'b0;
        intb = 1'b0;
    endtask

    task automatic port_access(input logic rd, input int s, input bus_data_t wd,
                               output bus_data_t rdv);
        reg_idx_t a;
        logic oe, got, seen;
        int cyc;
        case (s)
            0: a = `SDMAC_CSS_BASE + reg_idx_t'(rand_bits(3));
            1: a = `SDMAC_CSX0_BASE + reg_idx_t'(rand_bits(2));
            default: a = `SDMAC_CSX1_BASE + reg_idx_t'(rand_bits(2));
        endcase
        host_access(rd, a, 1'b0, wd, 60, rdv, oe, cyc, got, seen);
        if (!got) begin
            $display("error at %0t: no ack for peripheral index %0d", $time, a);
            errors++;
        end else begin
            compare("data_oe", 32'(rd), 32'(oe));
            compare("select", 32'(3'b001 << s), 32'(seen_sel));
            compare("pd_oe", 32'(!rd), 32'(seen_oe));
            compare("led_rd", 32'(rd), 32'(led_rd));
            compare("led_wr", 32'(!rd), 32'(led_wr));
        end
    endtask

    initial begin
        int eb, i, k;
        bus_data_t rdv, wd;
        logic oe, got, seen;
        lfsr = LFSR_SEED;
        {cs, a12, read, inta, intb} = '0;
        addr = '0;
        data_in = '0;
        {m_dawr, m_wtc, m_cntr, m_inta, m_intb, m_dma, m_flush} = '0;
        for (i = 0; i < 3; i++)
            m_mem[i] = '0;
        reset = 1'b1;
        repeat (4) @(posedge sclk);
        @(negedge sclk);
        reset = 1'b0;

        eb = errors;
        for (i = 0; i < 8; i++) begin
            k = int'(rand_bits(2) % 3);
            wd = rand_bits(32);
            case (k)
                0: begin
                    reg_access(1'b0, `SDMAC_DAWR_IDX, wd, rdv);
                    m_dawr = wd[1:0];
                end
                1: begin
                    reg_access(1'b0, `SDMAC_WTC_IDX, wd, rdv);
                    m_wtc = wd[23:0];
                end
                default: begin
                    reg_access(1'b0, `SDMAC_CNTR_IDX, wd, rdv);
                    m_cntr = wd[5:0];
                end
            endcase
            reg_access(1'b1, `SDMAC_DAWR_IDX, '0, rdv);
            compare("dawr", {30'd0, m_dawr}, rdv);
            reg_access(1'b1, `SDMAC_WTC_IDX, '0, rdv);
            compare("wtc", {8'd0, m_wtc}, rdv);
            reg_access(1'b1, `SDMAC_CNTR_IDX, '0, rdv);
            compare("cntr", {26'd0, m_cntr}, rdv);
        end
        report_test(1, "register read-back", eb);

        eb = errors;
        wd = rand_bits(32);
        wd[2] = 1'b0;                      // Interrupt enable off first
        reg_access(1'b0, `SDMAC_CNTR_IDX, wd, rdv);
        m_cntr = wd[5:0];
        pulse_int(1'b0);
        m_inta = 1'b1;
        check_status();
        wd[2] = 1'b1;
        reg_access(1'b0, `SDMAC_CNTR_IDX, wd, rdv);
        m_cntr = wd[5:0];
        pulse_int(1'b1);
        m_intb = 1'b1;
        check_status();
        reg_access(1'b0, `SDMAC_CLR_INT_IDX, rand_bits(32), rdv);
        {m_inta, m_intb} = 2'b00;
        check_status();
        reg_access(rand_bits(1) != 0, `SDMAC_ST_DMA_IDX, rand_bits(32), rdv);
        {m_dma, m_flush} = 2'b10;
        check_status();
        reg_access(rand_bits(1) != 0, `SDMAC_FLUSH_IDX, rand_bits(32), rdv);
        m_flush = 1'b1;
        check_status();
        reg_access(rand_bits(1) != 0, `SDMAC_SP_DMA_IDX, rand_bits(32), rdv);
        m_dma = 1'b0;
        check_status();
        reg_access(rand_bits(1) != 0, `SDMAC_ST_DMA_IDX, rand_bits(32), rdv);
        {m_dma, m_flush} = 2'b10;          // Restart drops the flush flag
        check_status();
        report_test(2, "commands and interrupts", eb);

        eb = errors;
        for (i = 0; i < 12; i++) begin
            k = int'(rand_bits(2) % 3);
            wd = rand_bits(32);
            port_access(1'b0, k, wd, rdv);
            m_mem[k] = wd[15:0];
            compare("pd_out", 32'(wd[15:0]), 32'(seen_pd));
            compare("device memory", 32'(m_mem[k]), 32'(dev_mem[k]));
        end
        report_test(3, "peripheral writes", eb);

        eb = errors;
        for (i = 0; i < 12; i++) begin
            k = int'(rand_bits(2) % 3);
            port_access(1'b1, k, rand_bits(32), rdv);
            compare("port read data", {16'd0, m_mem[k] ^ 16'h5a5a}, rdv);
        end
        report_test(4, "peripheral reads", eb);

        eb = errors;
        for (i = 0; i < 3; i++) begin
            host_access(rand_bits(1) != 0, reg_idx_t'(rand_bits(5)), 1'b1, rand_bits(32),
                        40, rdv, oe, k, got, seen);
            if (got) begin
                $display("error at %0t: access with a12 high was acknowledged", $time);
                errors++;
            end
            compare("select or strobe", 32'd0, 32'(seen));
        end
        report_test(5, "ignored accesses", eb);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule : sdmac_tb

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/sdmac_pkg.sv
logic/sdmac_addr_decoder.sv
logic/sdmac_regs.sv
logic/sdmac_periph_port.sv
logic/sdmac_bus_resp.sv
logic/sdmac_top.sv
verification/sdmac_sva.sv
verification/sdmac_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the sdmac testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module sdmac_tb -f all.f -o sim_sdmac
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_sdmac > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
